/* design/regFile_params.svh */
/*
 * Register file sizing
 * Lane counts, register count and data width shared by the
 * scalar register file, its RAM and its init sequencer
 */
`ifndef REG_FILE_PARAMS_SVH
`define REG_FILE_PARAMS_SVH

// Issue lane groups
`define INT_LANES        2
`define COMPLEX_LANES    1
`define MEM_LANES        2
`define LOAD_LANES       1

// Physical register array
`define PREG_NUM         64
`define PREG_DATA_WIDTH  32

// RAM port counts, writes from int/complex/load and two reads per lane
`define REG_WRITE_NUM    (`INT_LANES + `COMPLEX_LANES + `LOAD_LANES)
`define REG_READ_NUM     ((`INT_LANES + `COMPLEX_LANES + `MEM_LANES) * 2)

`endif

/* design/RegFilePkg.sv */
/*
 * Register file types
 * Register number, data and stored entry types, the lane write
 * bundle and the init sequencer states
 */
`include "regFile_params.svh"

package RegFilePkg;

    // Physical register number
    typedef logic [$clog2(`PREG_NUM)-1:0] PRegNum;

    // Register value
    typedef logic [`PREG_DATA_WIDTH-1:0] PRegData;

    // Stored word
    typedef struct packed {
        logic    valid;
        PRegData data;
    } PRegEntry;

    // One lane's result write
    typedef struct packed {
        logic     we;
        PRegNum   regNum;
        PRegEntry entry;
    } PRegWrite;

    // Post-reset zeroing sweep
    typedef enum logic [1:0] {
        InitIdle,
        InitClearing,
        InitDone
    } InitState;

endpackage

/* design/MultiPortRam.sv */
/*
 * Multi-port RAM
 * Combinational read ports and clocked write ports over one
 * array; on an address collision the highest write port wins
 */
`timescale 1ns/1ps
`include "regFile_params.svh"

module MultiPortRam #(
    parameter int EntryNum   = `PREG_NUM,
    parameter int EntryWidth = $bits(RegFilePkg::PRegEntry),
    parameter int ReadNum    = `REG_READ_NUM,
    parameter int WriteNum   = `REG_WRITE_NUM
) (
    input  logic                 clk,
    input  logic                 we        [WriteNum],
    input  RegFilePkg::PRegNum   writeAddr [WriteNum],
    input  RegFilePkg::PRegEntry writeData [WriteNum],
    input  RegFilePkg::PRegNum   readAddr  [ReadNum],
    output RegFilePkg::PRegEntry readData  [ReadNum]
);

    logic [EntryWidth-1:0] mem [EntryNum];

    // Later ports override earlier ones in the same cycle
    always_ff @(posedge clk) begin
        for (int i = 0; i < WriteNum; i++) begin
            if (we[i]) begin
                mem[writeAddr[i]] <= writeData[i];
            end
        end
    end

    always_comb begin
        for (int i = 0; i < ReadNum; i++) begin
            readData[i] = mem[readAddr[i]];
        end
    end

endmodule

/* design/RegInitSequencer.sv */
/*
 * Register init sequencer
 * Runs the post-reset sweep that writes a valid zero into every
 * physical register, one group of write ports per cycle
 */
`timescale 1ns/1ps
`include "regFile_params.svh"

module RegInitSequencer (
    input  logic               clk,
    input  logic               arstN,
    output logic               initBusy,
    output RegFilePkg::PRegNum sweepBase
);
    import RegFilePkg::*;

    // Base of the final group in the sweep
    localparam PRegNum LastBase = PRegNum'(`PREG_NUM - `REG_WRITE_NUM);

    InitState state;

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            state     <= InitIdle;
            sweepBase <= '0;
        end else begin
            case (state)
                InitIdle: begin
                    state     <= InitClearing;
                    sweepBase <= '0;
                end
                InitClearing: begin
                    sweepBase <= sweepBase + PRegNum'(`REG_WRITE_NUM);
                    if (sweepBase == LastBase) begin
                        state <= InitDone;
                    end
                end
                default: begin
                    state <= InitDone;
                end
            endcase
        end
    end

    // Busy until the whole array holds zero
    assign initBusy = (state != InitDone);

endmodule

/* design/RegisterFile.sv */
/*
 * Scalar register file
 * Maps integer, complex and memory lane ports onto the shared RAM
 * and substitutes zeroing writes while the init sweep runs
 */
`timescale 1ns/1ps
`include "regFile_params.svh"

module RegisterFile (
    input  logic                 clk,
    input  logic                 initBusy,
    input  RegFilePkg::PRegNum   sweepBase,

    input  RegFilePkg::PRegWrite intWrite        [`INT_LANES],
    input  RegFilePkg::PRegWrite complexWrite    [`COMPLEX_LANES],
    input  RegFilePkg::PRegWrite loadWrite       [`LOAD_LANES],

    input  RegFilePkg::PRegNum   intSrcA         [`INT_LANES],
    input  RegFilePkg::PRegNum   intSrcB         [`INT_LANES],
    input  RegFilePkg::PRegNum   complexSrcA     [`COMPLEX_LANES],
    input  RegFilePkg::PRegNum   complexSrcB     [`COMPLEX_LANES],
    input  RegFilePkg::PRegNum   memSrcA         [`MEM_LANES],
    input  RegFilePkg::PRegNum   memSrcB         [`MEM_LANES],

    output RegFilePkg::PRegEntry intSrcDataA     [`INT_LANES],
    output RegFilePkg::PRegEntry intSrcDataB     [`INT_LANES],
    output RegFilePkg::PRegEntry complexSrcDataA [`COMPLEX_LANES],
    output RegFilePkg::PRegEntry complexSrcDataB [`COMPLEX_LANES],
    output RegFilePkg::PRegEntry memSrcDataA     [`MEM_LANES],
    output RegFilePkg::PRegEntry memSrcDataB     [`MEM_LANES]
);
    import RegFilePkg::*;

    // First port of each lane group
    localparam int ComplexBase = `INT_LANES;
    localparam int LoadBase    = `INT_LANES + `COMPLEX_LANES;
    localparam int MemBase     = `INT_LANES + `COMPLEX_LANES;

    localparam PRegEntry ZeroEntry = '{valid: 1'b1, data: '0};

    PRegWrite portWrite    [`REG_WRITE_NUM];

    logic     ramWe        [`REG_WRITE_NUM];
    PRegNum   ramWriteAddr [`REG_WRITE_NUM];
    PRegEntry ramWriteData [`REG_WRITE_NUM];
    PRegNum   ramReadAddr  [`REG_READ_NUM];
    PRegEntry ramReadData  [`REG_READ_NUM];

    MultiPortRam #(
        .EntryNum   (`PREG_NUM),
        .EntryWidth ($bits(PRegEntry)),
        .ReadNum    (`REG_READ_NUM),
        .WriteNum   (`REG_WRITE_NUM)
    ) phyReg (
        .clk       (clk),
        .we        (ramWe),
        .writeAddr (ramWriteAddr),
        .writeData (ramWriteData),
        .readAddr  (ramReadAddr),
        .readData  (ramReadData)
    );

    // Lane writes in port order: int, complex, load
    always_comb begin
        for (int i = 0; i < `INT_LANES; i++) begin
            portWrite[i] = intWrite[i];
        end
        for (int i = 0; i < `COMPLEX_LANES; i++) begin
            portWrite[ComplexBase + i] = complexWrite[i];
        end
        for (int i = 0; i < `LOAD_LANES; i++) begin
            portWrite[LoadBase + i] = loadWrite[i];
        end
    end

    // Sweep takes over every write port until init is done
    always_comb begin
        for (int i = 0; i < `REG_WRITE_NUM; i++) begin
            if (initBusy) begin
                ramWe[i]        = 1'b1;
                ramWriteAddr[i] = sweepBase + PRegNum'(i);
                ramWriteData[i] = ZeroEntry;
            end else begin
                ramWe[i]        = portWrite[i].we;
                ramWriteAddr[i] = portWrite[i].regNum;
                ramWriteData[i] = portWrite[i].entry;
            end
        end
    end

    // Two read ports per lane, A then B
    always_comb begin
        for (int i = 0; i < `INT_LANES; i++) begin
            ramReadAddr[i*2]     = intSrcA[i];
            ramReadAddr[i*2 + 1] = intSrcB[i];
            intSrcDataA[i]       = ramReadData[i*2];
            intSrcDataB[i]       = ramReadData[i*2 + 1];
        end
        for (int i = 0; i < `COMPLEX_LANES; i++) begin
            ramReadAddr[(ComplexBase + i)*2]     = complexSrcA[i];
            ramReadAddr[(ComplexBase + i)*2 + 1] = complexSrcB[i];
            complexSrcDataA[i] = ramReadData[(ComplexBase + i)*2];
            complexSrcDataB[i] = ramReadData[(ComplexBase + i)*2 + 1];
        end
        for (int i = 0; i < `MEM_LANES; i++) begin
            ramReadAddr[(MemBase + i)*2]     = memSrcA[i];
            ramReadAddr[(MemBase + i)*2 + 1] = memSrcB[i];
            memSrcDataA[i] = ramReadData[(MemBase + i)*2];
            memSrcDataB[i] = ramReadData[(MemBase + i)*2 + 1];
        end
    end

endmodule

/* design/RegFileTop.sv */
/*
 * Register file top
 * Ties the init sequencer to the scalar register file and
 * exposes the lane write and operand read ports
 */
`timescale 1ns/1ps
`include "regFile_params.svh"

module RegFileTop (
    input  logic                 clk,
    input  logic                 arstN,

    input  RegFilePkg::PRegWrite intWrite        [`INT_LANES],
    input  RegFilePkg::PRegWrite complexWrite    [`COMPLEX_LANES],
    input  RegFilePkg::PRegWrite loadWrite       [`LOAD_LANES],

    input  RegFilePkg::PRegNum   intSrcA         [`INT_LANES],
    input  RegFilePkg::PRegNum   intSrcB         [`INT_LANES],
    input  RegFilePkg::PRegNum   complexSrcA     [`COMPLEX_LANES],
    input  RegFilePkg::PRegNum   complexSrcB     [`COMPLEX_LANES],
    input  RegFilePkg::PRegNum   memSrcA         [`MEM_LANES],
    input  RegFilePkg::PRegNum   memSrcB         [`MEM_LANES],

    output RegFilePkg::PRegEntry intSrcDataA     [`INT_LANES],
    output RegFilePkg::PRegEntry intSrcDataB     [`INT_LANES],
    output RegFilePkg::PRegEntry complexSrcDataA [`COMPLEX_LANES],
    output RegFilePkg::PRegEntry complexSrcDataB [`COMPLEX_LANES],
    output RegFilePkg::PRegEntry memSrcDataA     [`MEM_LANES],
    output RegFilePkg::PRegEntry memSrcDataB     [`MEM_LANES],
    output logic                 initBusy
);
    import RegFilePkg::*;

    PRegNum sweepBase;

    RegInitSequencer initSeq0 (
        .clk       (clk),
        .arstN     (arstN),
        .initBusy  (initBusy),
        .sweepBase (sweepBase)
    );

    RegisterFile regFile0 (
        .clk             (clk),
        .initBusy        (initBusy),
        .sweepBase       (sweepBase),
        .intWrite        (intWrite),
        .complexWrite    (complexWrite),
        .loadWrite       (loadWrite),
        .intSrcA         (intSrcA),
        .intSrcB         (intSrcB),
        .complexSrcA     (complexSrcA),
        .complexSrcB     (complexSrcB),
        .memSrcA         (memSrcA),
        .memSrcB         (memSrcB),
        .intSrcDataA     (intSrcDataA),
        .intSrcDataB     (intSrcDataB),
        .complexSrcDataA (complexSrcDataA),
        .complexSrcDataB (complexSrcDataB),
        .memSrcDataA     (memSrcDataA),
        .memSrcDataB     (memSrcDataB)
    );

endmodule

/* bench/RegFileTb.sv */
/*
 * Register file testbench
 * Random and directed lane traffic against a model of the
 * physical register array, including the post-reset sweep
 */
`timescale 1ns/1ps
`include "regFile_params.svh"

module RegFileTb;
    import RegFilePkg::*;

    localparam int ResetCycles  = 10;
    localparam int SweepCycles  = `PREG_NUM / `REG_WRITE_NUM;
    localparam int RandomCycles = 2000;
    localparam int OrderBase    = 40;
    localparam int ComplexPort  = `INT_LANES;
    localparam int LoadPort     = `INT_LANES + `COMPLEX_LANES;
    localparam int ComplexRead  = 2 * `INT_LANES;
    localparam int MemRead      = 2 * (`INT_LANES + `COMPLEX_LANES);
    // Two resets with sweep and zero check, random run, collisions, port order
    localparam int PlannedCycles = 2 * (ResetCycles + SweepCycles + 1 + `PREG_NUM)
        + RandomCycles + 2 * (1 << `REG_WRITE_NUM) + 2 * `REG_WRITE_NUM;
    localparam int TimeoutCycles = 2 * PlannedCycles;

    localparam PRegEntry ZeroEntry = '{valid: 1'b1, data: '0};

    logic     clk;
    logic     arstN;
    PRegWrite intWrite        [`INT_LANES];
    PRegWrite complexWrite    [`COMPLEX_LANES];
    PRegWrite loadWrite       [`LOAD_LANES];
    PRegNum   intSrcA         [`INT_LANES];
    PRegNum   intSrcB         [`INT_LANES];
    PRegNum   complexSrcA     [`COMPLEX_LANES];
    PRegNum   complexSrcB     [`COMPLEX_LANES];
    PRegNum   memSrcA         [`MEM_LANES];
    PRegNum   memSrcB         [`MEM_LANES];
    PRegEntry intSrcDataA     [`INT_LANES];
    PRegEntry intSrcDataB     [`INT_LANES];
    PRegEntry complexSrcDataA [`COMPLEX_LANES];
    PRegEntry complexSrcDataB [`COMPLEX_LANES];
    PRegEntry memSrcDataA     [`MEM_LANES];
    PRegEntry memSrcDataB     [`MEM_LANES];
    logic     initBusy;

    // Flat views in RAM port order
    PRegWrite wrPort [`REG_WRITE_NUM];
    PRegNum   rdNum  [`REG_READ_NUM];
    PRegEntry rdData [`REG_READ_NUM];

    PRegEntry model [`PREG_NUM];
    integer   seed = 32'h6c2a506f;
    int       cycleCount = 0;

    RegFileTop dut0 (
        .clk             (clk),
        .arstN           (arstN),
        .intWrite        (intWrite),
        .complexWrite    (complexWrite),
        .loadWrite       (loadWrite),
        .intSrcA         (intSrcA),
        .intSrcB         (intSrcB),
        .complexSrcA     (complexSrcA),
        .complexSrcB     (complexSrcB),
        .memSrcA         (memSrcA),
        .memSrcB         (memSrcB),
        .intSrcDataA     (intSrcDataA),
        .intSrcDataB     (intSrcDataB),
        .complexSrcDataA (complexSrcDataA),
        .complexSrcDataB (complexSrcDataB),
        .memSrcDataA     (memSrcDataA),
        .memSrcDataB     (memSrcDataB),
        .initBusy        (initBusy)
    );

    initial clk = 1'b0;
    always #5 clk = ~clk;

    always @(posedge clk) begin
        cycleCount <= cycleCount + 1;
        if (cycleCount >= TimeoutCycles) begin
            $display("Timeout: the run did not finish within %0d cycles", TimeoutCycles);
            $display("Test failures found");
            $fatal(1, "simulation stopped by the cycle limit");
        end
    end

    // Lane ports: int, complex, load writes; int, complex, mem reads A then B
    always_comb begin
        for (int i = 0; i < `INT_LANES; i++) begin
            intWrite[i] = wrPort[i];
            intSrcA[i]  = rdNum[2*i];
            intSrcB[i]  = rdNum[2*i + 1];
        end
        for (int i = 0; i < `COMPLEX_LANES; i++) begin
            complexWrite[i] = wrPort[ComplexPort + i];
            complexSrcA[i]  = rdNum[ComplexRead + 2*i];
            complexSrcB[i]  = rdNum[ComplexRead + 2*i + 1];
        end
        for (int i = 0; i < `LOAD_LANES; i++) begin
            loadWrite[i] = wrPort[LoadPort + i];
        end
        for (int i = 0; i < `MEM_LANES; i++) begin
            memSrcA[i] = rdNum[MemRead + 2*i];
            memSrcB[i] = rdNum[MemRead + 2*i + 1];
        end
    end

    always_comb begin
        for (int i = 0; i < `INT_LANES; i++) begin
            rdData[2*i]     = intSrcDataA[i];
            rdData[2*i + 1] = intSrcDataB[i];
        end
        for (int i = 0; i < `COMPLEX_LANES; i++) begin
            rdData[ComplexRead + 2*i]     = complexSrcDataA[i];
            rdData[ComplexRead + 2*i + 1] = complexSrcDataB[i];
        end
        for (int i = 0; i < `MEM_LANES; i++) begin
            rdData[MemRead + 2*i]     = memSrcDataA[i];
            rdData[MemRead + 2*i + 1] = memSrcDataB[i];
        end
    end

    function automatic logic [31:0] randWord();
        return $random(seed);
    endfunction

    function automatic PRegNum randNum();
        logic [31:0] r;
        r = $random(seed);
        return r[$bits(PRegNum)-1:0];
    endfunction

    task automatic checkEqual(input logic [63:0] got, input logic [63:0] exp,
                              input string what);
        if (got !== exp) begin
            $display("Fail at %0t ns: %s, got %0h expected %0h", $time, what, got, exp);
            $display("Test failures found");
            $fatal(1, "stopping at the first mismatch");
        end
    endtask

    task automatic clearModel();
        for (int i = 0; i < `PREG_NUM; i++) begin
            model[i] = ZeroEntry;
        end
    endtask

    task automatic driveIdle();
        for (int p = 0; p < `REG_WRITE_NUM; p++) begin
            wrPort[p] = '0;
        end
        for (int r = 0; r < `REG_READ_NUM; r++) begin
            rdNum[r] = '0;
        end
    endtask

    task automatic driveRandom();
        logic [31:0] r;
        for (int p = 0; p < `REG_WRITE_NUM; p++) begin
            r = randWord();
            wrPort[p].we          = r[0];
            wrPort[p].entry.valid = r[1];
            wrPort[p].regNum      = r[2 +: $bits(PRegNum)];
            wrPort[p].entry.data  = randWord();
        end
        for (int i = 0; i < `REG_READ_NUM; i++) begin
            rdNum[i] = randNum();
        end
    endtask

    task automatic checkReads();
        for (int r = 0; r < `REG_READ_NUM; r++) begin
            checkEqual(64'(rdData[r]), 64'(model[rdNum[r]]),
                       $sformatf("read port %0d of reg %0d", r, rdNum[r]));
        end
    endtask

    task automatic updateModel(input logic busy);
        if (busy) begin
            clearModel();
        end else begin
            for (int p = 0; p < `REG_WRITE_NUM; p++) begin
                if (wrPort[p].we) begin
                    model[wrPort[p].regNum] = wrPort[p].entry;
                end
            end
        end
    endtask

    // Reads checked mid cycle, writes applied at the edge, next drive 1 ns later
    task automatic stepCycle(input logic expBusy);
        @(negedge clk);
        checkEqual(64'(initBusy), 64'(expBusy), "initBusy level");
        if (!expBusy) begin
            checkReads();
        end
        @(posedge clk);
        updateModel(expBusy);
        #1;
    endtask

    task automatic expectAllZero();
        for (int i = 0; i < `PREG_NUM; i++) begin
            driveIdle();
            for (int r = 0; r < `REG_READ_NUM; r++) begin
                rdNum[r] = PRegNum'((i + r) % `PREG_NUM);
            end
            @(negedge clk);
            checkEqual(64'(initBusy), 64'(0), "initBusy high after the sweep");
            for (int r = 0; r < `REG_READ_NUM; r++) begin
                checkEqual(64'(rdData[r]), 64'(ZeroEntry),
                           $sformatf("zero check port %0d reg %0d", r, rdNum[r]));
            end
            @(posedge clk);
            #1;
        end
    endtask

    task automatic checkInitSweep();
        int busyCount;
        busyCount = 0;
        @(posedge clk);
        #1;
        while (initBusy) begin
            busyCount++;
            @(posedge clk);
            #1;
        end
        checkEqual(64'(busyCount), 64'(SweepCycles), "initBusy cycle count");
        expectAllZero();
        clearModel();
    endtask

    task automatic runRandomTraffic();
        repeat (RandomCycles) begin
            driveRandom();
            stepCycle(1'b0);
        end
    endtask

    task automatic forceCollisions();
        PRegNum   target;
        PRegEntry winner;
        for (int mask = 3; mask < (1 << `REG_WRITE_NUM); mask++) begin
            if ($countones(mask) < 2) begin
                continue;
            end
            target = randNum();
            winner = '0;
            driveRandom();
            // Ascending scan, so the highest port in the mask ends as winner
            for (int p = 0; p < `REG_WRITE_NUM; p++) begin
                wrPort[p].we = mask[p];
                if (mask[p]) begin
                    wrPort[p].regNum      = target;
                    wrPort[p].entry.valid = 1'b1;
                    winner = wrPort[p].entry;
                end
            end
            stepCycle(1'b0);
            driveIdle();
            for (int r = 0; r < `REG_READ_NUM; r++) begin
                rdNum[r] = target;
            end
            @(negedge clk);
            for (int r = 0; r < `REG_READ_NUM; r++) begin
                checkEqual(64'(rdData[r]), 64'(winner),
                           $sformatf("collision mask %0h port %0d", mask, r));
            end
            @(posedge clk);
            #1;
        end
    endtask

    task automatic resetUnderTraffic();
        arstN = 1'b0;
        repeat (ResetCycles) begin
            driveRandom();
            stepCycle(1'b1);
        end
        arstN = 1'b1;
        // Idle cycle, then lane writes keep coming while the sweep owns the ports
        repeat (SweepCycles + 1) begin
            driveRandom();
            stepCycle(1'b1);
        end
        expectAllZero();
    endtask

    task automatic verifyPortOrder();
        PRegEntry    written [`REG_WRITE_NUM];
        logic [31:0] w;
        for (int round = 0; round < `REG_WRITE_NUM; round++) begin
            for (int p = 0; p < `REG_WRITE_NUM; p++) begin
                w = randWord();
                written[p] = '{valid: 1'b1, data: {w[31:8], 8'(p)}};
                wrPort[p].we     = 1'b1;
                wrPort[p].regNum = PRegNum'(OrderBase + p);
                wrPort[p].entry  = written[p];
            end
            for (int r = 0; r < `REG_READ_NUM; r++) begin
                rdNum[r] = PRegNum'(OrderBase + r % `REG_WRITE_NUM);
            end
            stepCycle(1'b0);
            driveIdle();
            for (int r = 0; r < `REG_READ_NUM; r++) begin
                rdNum[r] = PRegNum'(OrderBase + (r + round) % `REG_WRITE_NUM);
            end
            @(negedge clk);
            for (int r = 0; r < `REG_READ_NUM; r++) begin
                checkEqual(64'(rdData[r]), 64'(written[(r + round) % `REG_WRITE_NUM]),
                           $sformatf("port order read %0d round %0d", r, round));
            end
            @(posedge clk);
            #1;
        end
    endtask

    initial begin
        arstN = 1'b0;
        driveIdle();
        clearModel();
        repeat (ResetCycles) @(posedge clk);
        #1;
        arstN = 1'b1;
        checkInitSweep();
        runRandomTraffic();
        forceCollisions();
        resetUnderTraffic();
        verifyPortOrder();
        $display("All tests passed!");
        $finish;
    end

endmodule

/* compile.f */
+incdir+design
design/RegFilePkg.sv
design/MultiPortRam.sv
design/RegInitSequencer.sv
design/RegisterFile.sv
design/RegFileTop.sv
bench/RegFileTb.sv

/* Makefile */
TOP := RegFileTb

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing -f compile.f --top-module $(TOP)

run: build
	@out=$$(./obj_dir/V$(TOP)); echo "$$out"; echo "$$out" | grep -q "All tests passed!"

lint:
	verilator --lint-only -Wall +incdir+design design/RegFilePkg.sv \
		design/MultiPortRam.sv design/RegInitSequencer.sv \
		design/RegisterFile.sv design/RegFileTop.sv --top-module RegFileTop

clean:
	rm -rf obj_dir
